// ==== cdc_stripe_fifo.f ====
design/cdc_stripe_pkg.sv
design/stripe_writer.sv
design/lane_async_fifo.sv
design/stripe_reader.sv
design/cdc_stripe_fifo.sv
verification/cdc_stripe_fifo_tb.sv

// ==== design/cdc_stripe_fifo.sv ====
// wr_clk to rd_clk bridge, four striped async fifo lanes, order preserved
// 32 words of buffering, writes while wr_full is high are dropped

module cdc_stripe_fifo
(
   // write side
   input  logic                          wr_clk,
   input  logic                          wr_nreset,
   input  cdc_stripe_pkg::stripe_word_t  wr_din,
   input  logic                          wr_en,
   output logic                          wr_full,
   // read side
   input  logic                          rd_clk,
   input  logic                          rd_nreset,
   output cdc_stripe_pkg::stripe_word_t  rd_dout,
   input  logic                          rd_en,
   output logic                          rd_empty
);

   import cdc_stripe_pkg::*;

   // striper to lanes
   logic [LANES-1:0] lane_wr_en;
   logic [LANES-1:0] lane_wr_full;
   stripe_word_t     lane_wr_din;               // shared by all lanes

   // lanes to merger
   logic [LANES-1:0] lane_rd_en;
   logic [LANES-1:0] lane_rd_empty;
   stripe_word_t     lane_rd_dout [LANES];

   // ################################################
   // write side striper
   // ################################################

   stripe_writer u_writer
   (
      .wr_clk       (wr_clk),
      .wr_nreset    (wr_nreset),
      .wr_en        (wr_en),
      .wr_din       (wr_din),
      .wr_full      (wr_full),
      .lane_wr_en   (lane_wr_en),
      .lane_wr_din  (lane_wr_din),
      .lane_wr_full (lane_wr_full)
   );

   // ################################################
   // fifo lanes
   // ################################################

   for (genvar i = 0; i < LANES; i++)
   begin : g_lane
      lane_async_fifo u_lane
      (
         .wr_clk    (wr_clk),
         .wr_nreset (wr_nreset),
         .wr_en     (lane_wr_en[i]),
         .wr_din    (lane_wr_din),
         .wr_full   (lane_wr_full[i]),
         .rd_clk    (rd_clk),
         .rd_nreset (rd_nreset),
         .rd_en     (lane_rd_en[i]),
         .rd_dout   (lane_rd_dout[i]),
         .rd_empty  (lane_rd_empty[i])
      );
   end

   // read side merger
   stripe_reader u_reader
   (
      .rd_clk        (rd_clk),
      .rd_nreset     (rd_nreset),
      .rd_en         (rd_en),
      .rd_dout       (rd_dout),
      .rd_empty      (rd_empty),
      .lane_rd_en    (lane_rd_en),
      .lane_rd_dout  (lane_rd_dout),
      .lane_rd_empty (lane_rd_empty)
   );

endmodule : cdc_stripe_fifo

// ==== design/cdc_stripe_pkg.sv ====
// shared types and sizes for the striped cdc fifo
// LANES and LANE_DEPTH must both stay powers of two

package cdc_stripe_pkg;

   // ################################################
   // data word
   // ################################################

   localparam int WORD_W = 16;                 // payload width
   typedef logic [WORD_W-1:0] stripe_word_t;

   // ################################################
   // lane geometry
   // ################################################

   localparam int LANES      = 4;                    // async fifo lanes
   localparam int LANE_DEPTH = 8;                    // entries per lane, power of two
   localparam int LANE_AW    = $clog2(LANE_DEPTH);   // store address bits
   localparam int LANE_PW    = LANE_AW + 1;          // pointer bits incl wrap bit
   localparam int LANE_SELW  = $clog2(LANES);        // lane select bits

endpackage : cdc_stripe_pkg

// ==== design/lane_async_fifo.sv ====
// single dual-clock fifo lane, gray pointers and two-flop synchronizers
// strobes arrive pre-qualified, no second full or empty check inside

module lane_async_fifo
(
   // write port
   input  logic                          wr_clk,
   input  logic                          wr_nreset,
   input  logic                          wr_en,      // already qualified by striper
   input  cdc_stripe_pkg::stripe_word_t  wr_din,
   output logic                          wr_full,    // registered
   // read port
   input  logic                          rd_clk,
   input  logic                          rd_nreset,
   input  logic                          rd_en,      // already qualified by merger
   output cdc_stripe_pkg::stripe_word_t  rd_dout,    // head word, combinational
   output logic                          rd_empty    // registered
);

   import cdc_stripe_pkg::*;

   // write domain state
   logic [LANE_PW-1:0] wr_bin;
   logic [LANE_PW-1:0] wr_gray;
   logic [LANE_PW-1:0] wr_bin_nxt;
   logic [LANE_PW-1:0] wr_gray_nxt;
   logic [LANE_PW-1:0] rd_gray_meta;   // first sync stage, wr_clk
   logic [LANE_PW-1:0] rd_gray_sync;   // read pointer seen by writer

   // read domain state
   logic [LANE_PW-1:0] rd_bin;
   logic [LANE_PW-1:0] rd_gray;
   logic [LANE_PW-1:0] rd_bin_nxt;
   logic [LANE_PW-1:0] rd_gray_nxt;
   logic [LANE_PW-1:0] wr_gray_meta;   // first sync stage, rd_clk
   logic [LANE_PW-1:0] wr_gray_sync;   // write pointer seen by reader

   stripe_word_t mem [LANE_DEPTH];     // register file store

   // ################################################
   // write side
   // ################################################

   assign wr_bin_nxt  = wr_bin + wr_en;
   assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);   // bin to gray

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else
      begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_gray_nxt;   // same edge as binary
      end
   end

   // full when next write pointer laps the read pointer by one depth
   // top two gray bits differ, the rest match
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
         wr_full <= 1'b0;
      else
         wr_full <= (wr_gray_nxt == {~rd_gray_sync[LANE_PW-1:LANE_PW-2],
                                      rd_gray_sync[LANE_PW-3:0]});
   end

   // read pointer into wr_clk, two flops per bit
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end
      else
      begin
         rd_gray_meta <= rd_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   // ################################################
   // read side
   // ################################################

   assign rd_bin_nxt  = rd_bin + rd_en;
   assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end
      else
      begin
         rd_bin  <= rd_bin_nxt;
         rd_gray <= rd_gray_nxt;
      end
   end

   // empty when the next read pointer catches the synced write pointer
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
         rd_empty <= 1'b1;   // empty out of reset
      else
         rd_empty <= (rd_gray_nxt == wr_gray_sync);
   end

   // write pointer into rd_clk, two flops per bit
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end
      else
      begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   // ################################################
   // store
   // ################################################

   always_ff @(posedge wr_clk)
   begin
      if (wr_en)
         mem[wr_bin[LANE_AW-1:0]] <= wr_din;   // drop wrap bit for address
   end

   assign rd_dout = mem[rd_bin[LANE_AW-1:0]];   // valid while rd_empty low

endmodule : lane_async_fifo

// ==== design/stripe_reader.sv ====
// round-robin collector on the read side, same lane order as the writer
// rd_dout only meaningful while rd_empty is low

module stripe_reader
(
   input  logic                               rd_clk,
   input  logic                               rd_nreset,
   input  logic                               rd_en,          // read strobe
   output cdc_stripe_pkg::stripe_word_t       rd_dout,        // head of current lane
   output logic                               rd_empty,       // current lane empty
   output logic [cdc_stripe_pkg::LANES-1:0]   lane_rd_en,     // one-hot lane strobe
   input  cdc_stripe_pkg::stripe_word_t       lane_rd_dout [cdc_stripe_pkg::LANES],
   input  logic [cdc_stripe_pkg::LANES-1:0]   lane_rd_empty
);

   import cdc_stripe_pkg::*;

   logic [LANE_SELW-1:0] rd_sel;   // lane holding the oldest word
   logic                 rd_take;  // read really happens this edge

   assign rd_empty = lane_rd_empty[rd_sel];
   assign rd_dout  = lane_rd_dout[rd_sel];   // output mux
   assign rd_take  = rd_en & ~rd_empty;

   // strobe only the pointed lane on a taken read
   always_comb
   begin
      lane_rd_en         = '0;
      lane_rd_en[rd_sel] = rd_take;
   end

   // lane pointer, one step per taken word
   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
         rd_sel <= '0;
      else if (rd_take)
         rd_sel <= rd_sel + 1'b1;   // wraps at LANES
   end

endmodule : stripe_reader

// ==== design/stripe_writer.sv ====
// round-robin dealer on the write side, lane pointer wraps naturally
// writes seen while the selected lane is full are dropped here

module stripe_writer
(
   input  logic                                 wr_clk,
   input  logic                                 wr_nreset,
   input  logic                                 wr_en,        // write strobe
   input  cdc_stripe_pkg::stripe_word_t         wr_din,
   output logic                                 wr_full,      // selected lane full
   output logic [cdc_stripe_pkg::LANES-1:0]     lane_wr_en,   // one-hot lane strobe
   output cdc_stripe_pkg::stripe_word_t         lane_wr_din,  // broadcast to all lanes
   input  logic [cdc_stripe_pkg::LANES-1:0]     lane_wr_full
);

   import cdc_stripe_pkg::*;

   logic [LANE_SELW-1:0] wr_sel;    // lane that takes the next word
   logic                 wr_accept; // write really happens this edge

   assign wr_full     = lane_wr_full[wr_sel];   // only the current lane matters
   assign wr_accept   = wr_en & ~wr_full;
   assign lane_wr_din = wr_din;                 // same word to every lane

   // strobe only the selected lane, and only on a real write
   always_comb
   begin
      lane_wr_en         = '0;
      lane_wr_en[wr_sel] = wr_accept;
   end

   // lane pointer, one step per accepted word
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
         wr_sel <= '0;
      else if (wr_accept)
         wr_sel <= wr_sel + 1'b1;   // wraps at LANES
   end

endmodule : stripe_writer

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal --top-module cdc_stripe_fifo_tb \
   -f cdc_stripe_fifo.f -Mdir obj_dir > build.log 2>&1 \
   && ./obj_dir/Vcdc_stripe_fifo_tb > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed"; exit 1; }

// ==== verification/cdc_stripe_fifo_tb.sv ====
// self-checking testbench, queue model, wr_clk 4 ns and rd_clk 6 ns
// rd_clk is offset half a ns so its edges never meet wr_clk edges

module cdc_stripe_fifo_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import cdc_stripe_pkg::*;

   // ################################################
   // run constants
   // ################################################

   localparam real WR_PERIOD     = 4.0;
   localparam real RD_PERIOD     = 6.0;
   localparam int  RESET_CYCLES  = 8;
   localparam int  CAPACITY      = LANES * LANE_DEPTH;   // 32 words over all lanes
   localparam int  ORDER_CYCLES  = 300;
   localparam int  RANDOM_CYCLES = 2000;
   localparam int  RD_CYCLES     = int'(RANDOM_CYCLES * WR_PERIOD / RD_PERIOD);
   localparam int  DRAIN_LIMIT   = 200;                  // rd_clk cycles per drain
   localparam int  TOTAL_OPS     = RESET_CYCLES + 40 + ORDER_CYCLES + 2 * CAPACITY
                                   + RANDOM_CYCLES + 3 * DRAIN_LIMIT;
   localparam real WATCHDOG_NS   = TOTAL_OPS * RD_PERIOD * 4 + 1000.0;

   logic         wr_clk;
   logic         rd_clk;
   logic         wr_nreset;
   logic         rd_nreset;
   logic         wr_en;
   logic         rd_en;
   logic         wr_full;
   logic         rd_empty;
   stripe_word_t wr_din;
   stripe_word_t rd_dout;

   stripe_word_t model [$];   // words accepted but not yet read
   int           error_cnt = 0;
   int           push_cnt  = 0;
   int           pop_cnt   = 0;
   string        test_name = "init";

   cdc_stripe_fifo UUT
   (
      .wr_clk    (wr_clk),
      .wr_nreset (wr_nreset),
      .wr_din    (wr_din),
      .wr_en     (wr_en),
      .wr_full   (wr_full),
      .rd_clk    (rd_clk),
      .rd_nreset (rd_nreset),
      .rd_dout   (rd_dout),
      .rd_en     (rd_en),
      .rd_empty  (rd_empty)
   );

   initial
   begin
      wr_clk = 1'b0;
      forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
   end

   initial
   begin
      rd_clk = 1'b0;
      #0.5;   // phase offset
      forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired in test %s, the run did not finish", test_name);
      $display("** FAIL **");
      $finish;
   end

   // ################################################
   // compare helpers and random sources
   // ################################################

   task automatic check_word(input string name, input stripe_word_t exp, input stripe_word_t act);
      if (exp !== act)
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         error_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
         error_cnt++;
      end
   endtask

   function automatic stripe_word_t rand_word();
      logic [31:0] r;
      r = $urandom;
      return r[WORD_W-1:0];
   endfunction

   function automatic logic chance(input int unsigned pct);
      int unsigned r;
      r = $urandom % 100;
      return (r < pct);
   endfunction

   // ################################################
   // model monitors, sampled on each own clock edge
   // ################################################

   always @(posedge wr_clk)
   begin
      if (wr_nreset && rd_nreset)
      begin
         // selected lane cannot look full unless nearly everything is held
         if (wr_full && model.size() < CAPACITY - 3)
         begin
            $display("ERROR: wr_full high in %s with only %0d words held", test_name,
                     model.size());
            error_cnt++;
         end
         if (wr_en && !wr_full)
         begin
            model.push_back(wr_din);
            push_cnt++;
         end
      end
   end

   always @(posedge rd_clk)
   begin : rd_monitor
      stripe_word_t head;
      if (wr_nreset && rd_nreset)
      begin
         if (!rd_empty && model.size() == 0)
         begin
            $display("ERROR: rd_empty low in %s while no word is held", test_name);
            error_cnt++;
         end
         else if (rd_en && !rd_empty)
         begin
            head = model.pop_front();
            check_word({test_name, " data"}, head, rd_dout);
            pop_cnt++;
         end
      end
   end

   // ################################################
   // test steps
   // ################################################

   task automatic apply_reset();
      wr_nreset = 1'b0;
      rd_nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge wr_clk);
      #1;
      wr_nreset = 1'b1;
      rd_nreset = 1'b1;
   endtask

   task automatic check_reset_state();
      test_name = "reset";
      check_flag("reset wr_full", 1'b0, wr_full);
      check_flag("reset rd_empty", 1'b1, rd_empty);
      repeat (10)
      begin
         @(posedge rd_clk);
         #1;
         check_flag("idle rd_empty", 1'b1, rd_empty);   // nothing written yet
      end
   endtask

   // read until the model is empty, then expect rd_empty to settle and hold
   task automatic drain_to_empty(input string name);
      int waited;
      @(posedge rd_clk);
      #1;
      rd_en  = 1'b1;
      waited = 0;
      while (model.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge rd_clk);
         #1;
         waited++;
      end
      if (model.size() != 0)
      begin
         $display("ERROR: %s left %0d words after %0d rd_clk cycles", name, model.size(),
                  DRAIN_LIMIT);
         error_cnt++;
      end
      waited = 0;
      while (!rd_empty && waited < 10)
      begin
         @(posedge rd_clk);
         #1;
         waited++;
      end
      check_flag({name, " rd_empty"}, 1'b1, rd_empty);
      repeat (10)
      begin
         @(posedge rd_clk);
         #1;
         check_flag({name, " rd_empty held"}, 1'b1, rd_empty);
      end
      rd_en = 1'b0;
   endtask

   task automatic run_ordered_stream();
      test_name = "order";
      @(posedge rd_clk);
      #1;
      rd_en = 1'b1;   // reader always willing
      repeat (ORDER_CYCLES)
      begin
         @(posedge wr_clk);
         #1;
         wr_en  = chance(50);
         wr_din = rand_word();
      end
      @(posedge wr_clk);
      #1;
      wr_en = 1'b0;
      drain_to_empty("order drain");
   endtask

   task automatic fill_to_capacity();
      int start_push;
      int start_pop;
      int tries;
      test_name  = "capacity";
      start_push = push_cnt;
      @(posedge wr_clk);
      #1;
      wr_en  = 1'b1;
      wr_din = rand_word();
      tries  = 0;
      while (!wr_full && tries < 2 * CAPACITY)
      begin
         @(posedge wr_clk);
         #1;
         wr_din = rand_word();
         tries++;
      end
      if (!wr_full)
      begin
         $display("ERROR: wr_full never rose while writing with reads held off");
         error_cnt++;
      end
      check_word("capacity accepted", stripe_word_t'(CAPACITY),
                 stripe_word_t'(push_cnt - start_push));
      repeat (8)
      begin
         @(posedge wr_clk);
         #1;
         wr_din = rand_word();   // these attempts must be dropped
      end
      wr_en = 1'b0;
      repeat (10) @(posedge rd_clk);
      check_flag("capacity wr_full held", 1'b1, wr_full);
      check_flag("capacity rd_empty", 1'b0, rd_empty);
      check_word("capacity after drops", stripe_word_t'(CAPACITY),
                 stripe_word_t'(push_cnt - start_push));
      test_name = "drain";
      start_pop = pop_cnt;
      drain_to_empty("drain");
      check_word("drain read out", stripe_word_t'(CAPACITY),
                 stripe_word_t'(pop_cnt - start_pop));
      repeat (10) @(posedge wr_clk);
      #1;
      check_flag("drained wr_full", 1'b0, wr_full);
   endtask

   // heavy writes first to sit near full, then light writes to sit near empty
   task automatic run_random_traffic();
      test_name = "random";
      fork
         begin
            for (int i = 0; i < RANDOM_CYCLES; i++)
            begin
               @(posedge wr_clk);
               #1;
               wr_en  = chance((i < RANDOM_CYCLES / 2) ? 60 : 10);
               wr_din = rand_word();
            end
            @(posedge wr_clk);
            #1;
            wr_en = 1'b0;
         end
         begin
            for (int j = 0; j < RD_CYCLES; j++)
            begin
               @(posedge rd_clk);
               #1;
               rd_en = chance(40);
            end
         end
      join
      drain_to_empty("random drain");
   endtask

   initial
   begin
      void'($urandom(8));
      wr_nreset = 1'b0;
      rd_nreset = 1'b0;
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      wr_din    = '0;

      apply_reset();
      check_reset_state();
      run_ordered_stream();
      fill_to_capacity();
      run_random_traffic();

      $display("summary: %0d errors, %0d words written, %0d words read and checked",
               error_cnt, push_cnt, pop_cnt);
      if (error_cnt == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule : cdc_stripe_fifo_tb
